//--- hdl/icache_pkg.sv
package icache_pkg;

	// Address split is tag | index | offset
	localparam int addr_w         = 26;
	localparam int tag_w          = 15;
	localparam int index_w        = 5;
	localparam int offset_w       = 6;

	localparam int word_w         = 32;
	localparam int line_w         = 512;
	localparam int words_per_line = 16;
	localparam int num_ways       = 2;
	localparam int ram_depth      = 64;	// Sets times ways

	typedef logic [addr_w-1:0]   addr_t;	// Byte address
	typedef logic [tag_w-1:0]    tag_t;
	typedef logic [index_w-1:0]  index_t;
	typedef logic [offset_w-1:0] offset_t;
	typedef logic [word_w-1:0]   word_t;
	typedef logic [line_w-1:0]   line_t;
	typedef logic                way_t;	// Two ways, one bit
	typedef logic [index_w:0]    ram_addr_t;	// {index, way}
	typedef logic [addr_w-3:0]   wb_adr_t;	// Word address toward memory

	typedef struct packed {
		logic  valid;
		addr_t addr;
	} fetch_req_t;

	typedef struct packed {
		logic  valid;
		word_t data;
	} fetch_rsp_t;

	typedef struct packed {
		logic    cyc;
		logic    stb;
		logic    we;	// Reads only
		wb_adr_t adr;
	} wb_m2s_t;

	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_s2m_t;

	// LOOKUP is the hit response cycle, RESPOND the miss response cycle
	typedef enum logic [2:0] {IDLE, LOOKUP, FILL, REFILL, RESPOND} ctrl_state_t;

endpackage

//--- hdl/icache_bram.sv
`timescale 1ns/1ps

module icache_bram import icache_pkg::*; (
	input  logic      clk,
	input  logic      nrst,
	input  logic      en,	// Port enable
	input  logic      we,	// Write whole line
	input  ram_addr_t addr,
	input  line_t     din,
	output line_t     dout
);

	line_t mem [ram_depth];	// One line per set and way

	// Storage write, contents survive reset
	always_ff @(posedge clk) begin
		if (en && we) begin
			mem[addr] <= din;
		end
	end

	// Read-first output register, cleared by reset
	always_ff @(posedge clk) begin
		if (!nrst) begin
			dout <= '0;
		end else if (en) begin
			dout <= mem[addr];	// Old contents on a write cycle
		end
	end

endmodule

//--- hdl/icache_data_array.sv
`timescale 1ns/1ps

module icache_data_array import icache_pkg::*; (
	input  logic      clk,
	input  logic      nrst,
	input  ram_addr_t ram_addr,	// {index, way} of the access
	input  offset_t   offset,	// Byte offset of the wanted word
	input  logic      refill,	// Write fill_line this cycle
	input  line_t     fill_line,
	output word_t     rsp_word
);

	line_t   ram_dout;
	line_t   src_line;
	logic    refill_q;	// Refill aligned to RAM latency
	offset_t offset_q;	// Offset aligned to RAM latency

	icache_bram u_bram (
		.clk  (clk),
		.nrst (nrst),
		.en   (1'b1),	// Always reading
		.we   (refill),
		.addr (ram_addr),
		.din  (fill_line),
		.dout (ram_dout)
	);

	always_ff @(posedge clk) begin
		if (!nrst) begin
			refill_q <= 1'b0;
		end else begin
			refill_q <= refill;
		end
	end

	always_ff @(posedge clk) begin
		offset_q <= offset;
	end

	// Bypass the RAM in the cycle after a refill write
	assign src_line = refill_q ? fill_line : ram_dout;

	// Word select by offset bits 5 to 2
	assign rsp_word = src_line[{offset_q[offset_w-1:2], 5'b00000} +: word_w];

endmodule

//--- hdl/icache_tag_array.sv
`timescale 1ns/1ps

module icache_tag_array import icache_pkg::*; (
	input  logic   clk,
	input  logic   nrst,
	input  index_t index,	// Set under lookup or fill
	input  tag_t   tag,
	output logic   hit,
	output way_t   hit_way,
	output way_t   victim_way,	// Way to replace on a miss
	input  logic   tag_we,	// Install tag at {index, fill_way}
	input  way_t   fill_way,
	input  logic   touch,	// Hit access, mark hit_way recent
	input  logic   invalidate	// Clear all valid bits
);

	tag_t tag_mem [num_ways][ram_depth/num_ways];

	logic [num_ways-1:0][ram_depth/num_ways-1:0] valid_q;
	logic [ram_depth/num_ways-1:0]               lru_q;	// Way number of LRU entry

	logic [num_ways-1:0] way_hit;

	// Both ways compared in parallel
	always_comb begin
		for (int w = 0; w < num_ways; w++) begin
			way_hit[w] = valid_q[w][index] && (tag_mem[w][index] == tag);
		end
	end

	assign hit     = |way_hit;
	assign hit_way = way_hit[1];	// Way 0 unless way 1 matched

	// Prefer an empty way, else the LRU one
	always_comb begin
		if (!valid_q[0][index]) begin
			victim_way = 1'b0;
		end else if (!valid_q[1][index]) begin
			victim_way = 1'b1;
		end else begin
			victim_way = lru_q[index];
		end
	end

	// Tag storage
	always_ff @(posedge clk) begin
		if (tag_we) begin
			tag_mem[fill_way][index] <= tag;
		end
	end

	// Valid and LRU state
	always_ff @(posedge clk) begin
		if (!nrst) begin
			valid_q <= '0;
			lru_q   <= '0;	// LRU starts at way 0
		end else if (invalidate) begin
			valid_q <= '0;	// LRU bits kept, only validity lost
		end else if (tag_we) begin
			valid_q[fill_way][index] <= 1'b1;
			lru_q[index]             <= ~fill_way;	// Other way is now older
		end else if (touch) begin
			lru_q[index] <= ~hit_way;
		end
	end

endmodule

//--- hdl/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; (
	input  logic       clk,
	input  logic       nrst,
	input  fetch_req_t req,
	output logic       fetch_ready,
	output logic       rsp_valid,
	input  logic       invalidate_req,
	input  logic       hit,
	input  way_t       hit_way,
	input  way_t       victim_way,
	output index_t     lookup_index,
	output tag_t       lookup_tag,
	output logic       tag_we,
	output way_t       fill_way,
	output logic       touch,
	output logic       invalidate,
	output ram_addr_t  ram_addr,
	output offset_t    offset,
	output logic       refill,
	output line_t      fill_line,
	output wb_m2s_t    wb_m,
	input  wb_s2m_t    wb_s
);

	ctrl_state_t state_q;
	ctrl_state_t state_d;

	addr_t miss_addr_q;	// Address of the outstanding miss
	way_t  fill_way_q;	// Victim chosen at miss time
	line_t fill_buf_q;	// Line assembled from memory words
	logic [$clog2(words_per_line)-1:0] word_cnt_q;	// Words acked so far

	tag_t    req_tag;
	index_t  req_index;
	offset_t req_offset;
	tag_t    miss_tag;
	index_t  miss_index;
	offset_t miss_offset;

	logic can_accept;	// State that takes a new request
	logic accept;	// Request handshake this cycle
	logic filling;	// Miss in progress, latched address drives the arrays
	logic last_ack;	// Final word of the line acked

	// Address fields
	assign req_tag     = req.addr[addr_w-1 -: tag_w];
	assign req_index   = req.addr[offset_w +: index_w];
	assign req_offset  = req.addr[offset_w-1:0];
	assign miss_tag    = miss_addr_q[addr_w-1 -: tag_w];
	assign miss_index  = miss_addr_q[offset_w +: index_w];
	assign miss_offset = miss_addr_q[offset_w-1:0];

	assign can_accept = (state_q == IDLE) || (state_q == LOOKUP) || (state_q == RESPOND);
	assign filling    = (state_q == FILL) || (state_q == REFILL);
	assign last_ack   = (state_q == FILL) && wb_s.ack && (&word_cnt_q);

	// Invalidate only from idle, and it blocks the fetch port that cycle
	assign invalidate  = (state_q == IDLE) && invalidate_req;
	assign fetch_ready = can_accept && !invalidate;
	assign accept      = req.valid && fetch_ready;

	// Tag array side
	assign lookup_index = filling ? miss_index : req_index;
	assign lookup_tag   = filling ? miss_tag : req_tag;
	assign touch        = accept && hit;
	assign tag_we       = (state_q == REFILL);
	assign fill_way     = fill_way_q;

	// Data array side, hit read or refill write
	assign ram_addr  = filling ? {miss_index, fill_way_q} : {req_index, hit_way};
	assign offset    = filling ? miss_offset : req_offset;
	assign refill    = (state_q == REFILL);
	assign fill_line = fill_buf_q;

	// Response one cycle after a hit or after the refill write
	assign rsp_valid = (state_q == LOOKUP) || (state_q == RESPOND);

	// Wishbone classic single reads, one per word
	assign wb_m.cyc = (state_q == FILL);
	assign wb_m.stb = (state_q == FILL);
	assign wb_m.we  = 1'b0;
	assign wb_m.adr = {miss_tag, miss_index, word_cnt_q};	// Line base plus word

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE, LOOKUP, RESPOND: begin
				if (accept) begin
					state_d = hit ? LOOKUP : FILL;
				end else begin
					state_d = IDLE;
				end
			end
			FILL: begin
				if (last_ack) begin
					state_d = REFILL;	// cyc drops next cycle
				end
			end
			REFILL:  state_d = RESPOND;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state_q    <= IDLE;
			word_cnt_q <= '0;
		end else begin
			state_q <= state_d;
			if (accept && !hit) begin
				word_cnt_q <= '0;	// New line starts at word 0
			end else if ((state_q == FILL) && wb_s.ack) begin
				word_cnt_q <= word_cnt_q + 1'b1;	// Wraps to 0 after the last word
			end
		end
	end

	// Miss address and victim latched at acceptance
	always_ff @(posedge clk) begin
		if (accept && !hit) begin
			miss_addr_q <= req.addr;
			fill_way_q  <= victim_way;
		end
	end

	// Words shift in from the top, word 0 ends at the bottom
	always_ff @(posedge clk) begin
		if ((state_q == FILL) && wb_s.ack) begin
			fill_buf_q <= {wb_s.dat, fill_buf_q[line_w-1:word_w]};
		end
	end

endmodule

//--- hdl/icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
	input  logic       clk,
	input  logic       nrst,
	input  fetch_req_t req,
	output logic       fetch_ready,
	input  logic       invalidate_req,
	output fetch_rsp_t rsp,
	output wb_m2s_t    wb_m,
	input  wb_s2m_t    wb_s
);

	logic      rsp_valid;
	word_t     rsp_word;

	logic      hit;
	way_t      hit_way;
	way_t      victim_way;
	index_t    lookup_index;
	tag_t      lookup_tag;
	logic      tag_we;
	way_t      fill_way;
	logic      touch;
	logic      invalidate;

	ram_addr_t ram_addr;
	offset_t   offset;
	logic      refill;
	line_t     fill_line;

	icache_ctrl u_ctrl (
		.clk            (clk),
		.nrst           (nrst),
		.req            (req),
		.fetch_ready    (fetch_ready),
		.rsp_valid      (rsp_valid),
		.invalidate_req (invalidate_req),
		.hit            (hit),
		.hit_way        (hit_way),
		.victim_way     (victim_way),
		.lookup_index   (lookup_index),
		.lookup_tag     (lookup_tag),
		.tag_we         (tag_we),
		.fill_way       (fill_way),
		.touch          (touch),
		.invalidate     (invalidate),
		.ram_addr       (ram_addr),
		.offset         (offset),
		.refill         (refill),
		.fill_line      (fill_line),
		.wb_m           (wb_m),
		.wb_s           (wb_s)
	);

	icache_tag_array u_tag_array (
		.clk        (clk),
		.nrst       (nrst),
		.index      (lookup_index),
		.tag        (lookup_tag),
		.hit        (hit),
		.hit_way    (hit_way),
		.victim_way (victim_way),
		.tag_we     (tag_we),
		.fill_way   (fill_way),
		.touch      (touch),
		.invalidate (invalidate)
	);

	icache_data_array u_data_array (
		.clk       (clk),
		.nrst      (nrst),
		.ram_addr  (ram_addr),
		.offset    (offset),
		.refill    (refill),
		.fill_line (fill_line),
		.rsp_word  (rsp_word)
	);

	// Response word pairs with the registered valid
	assign rsp.valid = rsp_valid;
	assign rsp.data  = rsp_word;

endmodule

//--- tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk,
	output logic nrst
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset held low for the first 16 rising edges
	initial begin
		nrst = 1'b0;
		repeat (16) @(posedge clk);
		nrst <= 1'b1;
	end

endmodule

//--- tb/icache_checker.sv
`timescale 1ns/1ps

module icache_checker import icache_pkg::*; (
	input logic       clk,
	input logic       nrst,
	input fetch_req_t req,
	input logic       fetch_ready,
	input fetch_rsp_t rsp,
	input wb_m2s_t    wb_m,
	input wb_s2m_t    wb_s
);

	// Classic single read, request held until the slave acks
	a_stb_hold: assert property (@(posedge clk) disable iff (!nrst)
		(wb_m.stb && !wb_s.ack) |=> (wb_m.stb && $stable(wb_m.adr)))
		else $error("Wishbone stb dropped or adr changed before ack");

	a_rsp_outside_cyc: assert property (@(posedge clk) disable iff (!nrst)
		!(rsp.valid && wb_m.cyc))
		else $error("Fetch response raised during a Wishbone cycle");

	// Accepted request leads to a hit response or a line fill
	a_accept_next: assert property (@(posedge clk) disable iff (!nrst)
		(req.valid && fetch_ready) |=> (rsp.valid || wb_m.cyc))
		else $error("Accepted request gave neither a response nor a memory read");

	a_ready_in_fill: assert property (@(posedge clk) disable iff (!nrst)
		wb_m.cyc |-> !fetch_ready)
		else $error("Fetch port ready while a line fill is running");

	// Refill write cycle, port still closed
	a_ready_in_refill: assert property (@(posedge clk) disable iff (!nrst)
		$fell(wb_m.cyc) |-> !fetch_ready)
		else $error("Fetch port ready in the refill write cycle");

	a_rsp_after_refill: assert property (@(posedge clk) disable iff (!nrst)
		$fell(wb_m.cyc) |=> rsp.valid)
		else $error("No response in the cycle after the refill write");

endmodule

bind icache_top icache_checker u_checker (
	.clk         (clk),
	.nrst        (nrst),
	.req         (req),
	.fetch_ready (fetch_ready),
	.rsp         (rsp),
	.wb_m        (wb_m),
	.wb_s        (wb_s)
);

//--- tb/icache_tb.sv
`timescale 1ns/1ps

module icache_tb import icache_pkg::*; ();

	logic       clk;
	logic       nrst;
	fetch_req_t req            = '0;	// Fetch port toward the DUT
	logic       invalidate_req = 1'b0;
	wb_s2m_t    wb_s           = '0;	// Memory slave answer
	logic       fetch_ready;
	fetch_rsp_t rsp;
	wb_m2s_t    wb_m;

	int cycle_limit     = 400 * 80;	// 400 requests at 80 cycles each
	int cycle           = 0;
	int mismatch_errors = 0;
	int other_errors    = 0;

	logic [31:0] stim_state = 32'hcabd;	// LCG for addresses
	logic [31:0] wait_state = 32'hcabd;	// LCG for wait states
	logic [1:0]  wait_left  = 2'd0;

	// Reference tags, valid bits and LRU per set
	tag_t m_tag   [num_ways][2**index_w];
	logic m_valid [num_ways][2**index_w];
	way_t m_lru   [2**index_w];

	word_t   exp_word_q  [$];	// Expected words in request order
	logic    exp_hit_q   [$];
	int      exp_cycle_q [$];	// Accept cycle of each request
	wb_adr_t line_base = '0;	// First word address of the current miss
	int      acks_seen = 0;

	tb_clkgen u_clkgen (
		.clk  (clk),
		.nrst (nrst)
	);

	icache_top u_icache_top (
		.clk            (clk),
		.nrst           (nrst),
		.req            (req),
		.fetch_ready    (fetch_ready),
		.invalidate_req (invalidate_req),
		.rsp            (rsp),
		.wb_m           (wb_m),
		.wb_s           (wb_s)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Memory contents, fixed scramble of the word address
	function automatic word_t mix_word(input wb_adr_t a);
		logic [31:0] x;
		x = {8'h00, a} * 32'h9e3779b1;
		return x ^ {a[7:0], a} ^ 32'h5a5a0f0f;
	endfunction

	function automatic addr_t make_addr(input tag_t t, input index_t s, input logic [3:0] w);
		return {t, s, w, 2'b00};
	endfunction

	// Four tags over three sets, so lines collide and get evicted
	function automatic addr_t pick_addr(input logic [31:0] r);
		tag_t   t;
		index_t s;
		case (r[31:30])
			2'd0:    t = 15'h0123;
			2'd1:    t = 15'h4a5b;
			2'd2:    t = 15'h7ffe;
			default: t = 15'h2c3d;
		endcase
		case (r[29:28])
			2'd1:    s = 5'd17;
			2'd2:    s = 5'd31;
			default: s = 5'd2;	// Busiest set
		endcase
		return make_addr(t, s, r[27:24]);
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			mismatch_errors++;
			$display("MISMATCH %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			mismatch_errors++;
			$display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_adr(input string name, input wb_adr_t exp, input wb_adr_t act);
		if (act !== exp) begin
			mismatch_errors++;
			$display("MISMATCH %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// Reference lookup and update at acceptance
	task automatic note_accept(input addr_t a, output logic hit);
		tag_t   t;
		index_t s;
		way_t   w;
		t   = a[addr_w-1 -: tag_w];
		s   = a[offset_w +: index_w];
		hit = 1'b0;
		w   = 1'b0;
		for (int i = 0; i < num_ways; i++) begin
			if (m_valid[i][s] && (m_tag[i][s] == t)) begin
				hit = 1'b1;
				w   = i[0];
			end
		end
		if (!hit) begin
			if (!m_valid[0][s]) begin
				w = 1'b0;	// Empty way first
			end else if (!m_valid[1][s]) begin
				w = 1'b1;
			end else begin
				w = m_lru[s];
			end
			m_tag[w][s]   = t;
			m_valid[w][s] = 1'b1;
			line_base     = {a[addr_w-1:offset_w], 4'h0};
		end
		m_lru[s] = ~w;	// Other way becomes older
		exp_word_q.push_back(mix_word(a[addr_w-1:2]));
		exp_hit_q.push_back(hit);
		exp_cycle_q.push_back(cycle);
	endtask

	// Drive a request and return at its accept edge
	task automatic send_fetch(input addr_t a, output logic hit);
		req.valid <= 1'b1;
		req.addr  <= a;
		@(posedge clk);
		while (!fetch_ready) begin
			@(posedge clk);
		end
		note_accept(a, hit);
	endtask

	task automatic fetch_expect(input string name, input addr_t a, input logic exp_hit);
		logic hit;
		send_fetch(a, hit);
		check_count(name, int'(exp_hit), int'(hit));
	endtask

	task automatic drain();
		req.valid <= 1'b0;
		@(posedge clk);
		while (exp_word_q.size() != 0) begin
			@(posedge clk);
		end
		@(posedge clk);	// Controller back in IDLE
	endtask

	task automatic invalidate_all();
		drain();
		invalidate_req <= 1'b1;
		@(posedge clk);
		if (fetch_ready) begin
			other_errors++;
			$display("Invalidate was not taken while the cache was idle");
		end
		invalidate_req <= 1'b0;
		for (int s = 0; s < 2**index_w; s++) begin
			m_valid[0][s] = 1'b0;	// LRU bits survive
			m_valid[1][s] = 1'b0;
		end
	endtask

	// Wishbone slave with 0 to 3 wait states per word
	always @(posedge clk) begin : memory_slave
		if (!nrst) begin
			wb_s      <= '0;
			wait_left <= 2'd0;
		end else if (wb_s.ack) begin
			wb_s.ack <= 1'b0;	// Single-cycle ack
		end else if (wb_m.cyc && wb_m.stb) begin
			if (wait_left == 2'd0) begin
				wb_s.ack   <= 1'b1;
				wb_s.dat   <= mix_word(wb_m.adr);
				wait_state  = lcg_next(wait_state);
				wait_left  <= wait_state[31:30];	// Waits for the next word
			end else begin
				wait_left <= wait_left - 2'd1;
			end
		end
	end

	// Read addresses and responses against the queues
	always @(posedge clk) begin : monitor
		word_t exp_w;
		logic  exp_h;
		int    exp_c;
		if (nrst && wb_m.cyc && wb_m.stb && wb_s.ack) begin
			check_adr("miss read address", line_base + wb_adr_t'(acks_seen), wb_m.adr);
			if (wb_m.we) begin
				other_errors++;
				$display("Wishbone write issued during a line fill");
			end
			acks_seen++;
		end
		if (nrst && rsp.valid) begin
			if (exp_word_q.size() == 0) begin
				other_errors++;
				$display("Response arrived with no request outstanding");
			end else begin
				exp_w = exp_word_q.pop_front();
				exp_h = exp_hit_q.pop_front();
				exp_c = exp_cycle_q.pop_front();
				check_word("fetch data", exp_w, rsp.data);
				if (exp_h) begin
					check_count("hit reads", 0, acks_seen);
					check_count("hit latency", 1, cycle - exp_c);
				end else begin
					check_count("miss reads", words_per_line, acks_seen);
				end
			end
			acks_seen = 0;
		end
	end

	always @(posedge clk) begin : watchdog
		cycle <= cycle + 1;
		if (cycle >= cycle_limit) begin
			$display("Timeout, run did not finish within %0d cycles", cycle_limit);
			$display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin : stimulus
		logic hit;
		for (int s = 0; s < 2**index_w; s++) begin
			m_valid[0][s] = 1'b0;
			m_valid[1][s] = 1'b0;
			m_lru[s]      = 1'b0;	// Way 0 is LRU after reset
		end
		while (!nrst) begin
			@(posedge clk);
		end
		@(posedge clk);
		if (!fetch_ready || rsp.valid || wb_m.cyc || wb_m.stb) begin
			other_errors++;
			$display("Port state after reset is not idle");
		end

		// Third tag in set 7 evicts the older way
		fetch_expect("evict fill t0", make_addr(15'h1111, 5'd7, 4'd3), 1'b0);
		fetch_expect("evict fill t1", make_addr(15'h2222, 5'd7, 4'd9), 1'b0);
		fetch_expect("evict touch t0", make_addr(15'h1111, 5'd7, 4'd0), 1'b1);
		fetch_expect("evict t2 miss", make_addr(15'h3333, 5'd7, 4'd15), 1'b0);
		fetch_expect("evict kept t0", make_addr(15'h1111, 5'd7, 4'd5), 1'b1);
		fetch_expect("evict lost t1", make_addr(15'h2222, 5'd7, 4'd9), 1'b0);

		for (int i = 0; i < 370; i++) begin
			stim_state = lcg_next(stim_state);
			send_fetch(pick_addr(stim_state), hit);
			if (stim_state[19:18] == 2'd0) begin
				req.valid <= 1'b0;	// Occasional bubble
				@(posedge clk);
			end
		end

		// Earlier lines must all refetch
		invalidate_all();
		fetch_expect("inval t0", make_addr(15'h1111, 5'd7, 4'd5), 1'b0);
		fetch_expect("inval t1", make_addr(15'h2222, 5'd7, 4'd2), 1'b0);
		fetch_expect("inval pool a", make_addr(15'h0123, 5'd2, 4'd1), 1'b0);
		fetch_expect("inval pool b", make_addr(15'h4a5b, 5'd17, 4'd14), 1'b0);
		fetch_expect("refetched t0", make_addr(15'h1111, 5'd7, 4'd12), 1'b1);
		drain();

		$display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
		if ((mismatch_errors + other_errors) == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- sources.f
hdl/icache_pkg.sv
hdl/icache_bram.sv
hdl/icache_data_array.sv
hdl/icache_tag_array.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
tb/tb_clkgen.sv
tb/icache_checker.sv
tb/icache_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -f sources.f --top-module icache_tb -o icache_sim &&
./obj_dir/icache_sim | tee /dev/stderr | grep -F '>>> PASS' > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
